// File: common/ps2Pkg.sv
`default_nettype none

package ps2Pkg;

    ////////////////////
    // Data widths
    ////////////////////

    // One data byte of a PS/2 frame
    typedef logic [7:0] ps2Byte_t;

    // Up to four bytes, oldest byte in the top lane
    typedef logic [31:0] scanCode_t;

    // Bit position within a frame, 0 to 10
    typedef logic [3:0] bitCount_t;

    // Idle timeout counter
    typedef logic [12:0] timeoutCount_t;

    // Line filter stability counter
    typedef logic [4:0] filterCount_t;

    ////////////////////
    // Timing
    ////////////////////

    // Cycles a raw line must hold still before the filtered copy follows
    localparam int filterCycles = 20;

    // Cycles without a keyboard clock edge before a partial frame is dropped
    localparam int frameTimeoutCycles = 4096;

    ////////////////////
    // Scan code prefixes
    ////////////////////

    // Extended key
    localparam ps2Byte_t prefixExtended = 8'hE0;
    // Key release
    localparam ps2Byte_t prefixRelease = 8'hF0;

    // Frame decoder states
    typedef enum logic [1:0] {
        idle,
        receiving,
        done
    } decodeState_t;

endpackage

`default_nettype wire

// File: common/ps2FrameIf.sv
`timescale 1ns/1ns
`default_nettype none

interface ps2FrameIf;
    import ps2Pkg::*;

    // Received byte, meaningful only while valid is high
    ps2Byte_t data;
    // Single-cycle strobe per frame
    logic     valid;
    // Odd parity check failed
    logic     parityError;
    // Bad start or stop bit
    logic     framingError;

    // Decoder side
    modport sender (output data, output valid, output parityError, output framingError);

    // Assembler side, must take the byte in the valid cycle
    modport receiver (input data, input valid, input parityError, input framingError);

endinterface

`default_nettype wire

// File: logic/ps2LineFilter.sv
`timescale 1ns/1ns
`default_nettype none

module ps2LineFilter (
    input  logic clk,
    input  logic rst,
    input  logic kclk,
    input  logic kdata,
    output logic kclkFiltered,
    output logic kdataFiltered
);
    import ps2Pkg::*;

    // Lane 0 is the keyboard clock, lane 1 the data line
    logic [1:0] rawLines;
    logic [1:0] cleanLines;

    assign rawLines      = {kdata, kclk};
    assign kclkFiltered  = cleanLines[0];
    assign kdataFiltered = cleanLines[1];

    genvar lineIdx;
    generate
        for (lineIdx = 0; lineIdx < 2; lineIdx++) begin : gLine
            logic         lastSeen;
            logic         filtered;
            filterCount_t stableCount;

            always_ff @(posedge clk) begin
                if (rst) begin
                    // Both lines idle high
                    lastSeen    <= 1'b1;
                    filtered    <= 1'b1;
                    stableCount <= '0;
                end else if (rawLines[lineIdx] != lastSeen) begin
                    // Any change restarts the count
                    lastSeen    <= rawLines[lineIdx];
                    stableCount <= '0;
                end else if (stableCount == filterCount_t'(filterCycles - 1)) begin
                    // Held long enough, pass it on
                    filtered <= lastSeen;
                end else begin
                    stableCount <= stableCount + filterCount_t'(1);
                end
            end

            assign cleanLines[lineIdx] = filtered;
        end
    endgenerate

endmodule

`default_nettype wire

// File: ps2Frame/ps2FrameDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module ps2FrameDecoder (
    input  logic        clk,
    input  logic        rst,
    input  logic        kclkFiltered,
    input  logic        kdataFiltered,
    ps2FrameIf.sender   frame
);
    import ps2Pkg::*;

    decodeState_t  state;
    bitCount_t     bitCount;
    timeoutCount_t timeoutCount;
    logic          kclkPrev;
    logic          fallingEdge;

    // Frame payload
    ps2Byte_t shiftReg;
    logic     parityAcc;
    logic     startBad;
    logic     framingBad;

    // Keyboard clock edge in the clk domain
    assign fallingEdge = kclkPrev & ~kclkFiltered;

    ////////////////////
    // Control FSM
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= idle;
            bitCount     <= '0;
            timeoutCount <= '0;
            kclkPrev     <= 1'b1;
        end else begin
            kclkPrev <= kclkFiltered;
            unique case (state)
                idle: begin
                    timeoutCount <= '0;
                    if (fallingEdge) begin
                        // Start bit taken, next edge is data bit 0
                        bitCount <= 4'd1;
                        state    <= receiving;
                    end
                end
                receiving: begin
                    if (fallingEdge) begin
                        timeoutCount <= '0;
                        if (bitCount == 4'd10) begin
                            state <= done;
                        end else begin
                            bitCount <= bitCount + 4'd1;
                        end
                    end else if (timeoutCount == timeoutCount_t'(frameTimeoutCycles - 1)) begin
                        // Keyboard went quiet mid frame
                        state <= idle;
                    end else begin
                        timeoutCount <= timeoutCount + timeoutCount_t'(1);
                    end
                end
                done: begin
                    // One cycle strobe only
                    state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    ////////////////////
    // Bit shifter
    ////////////////////

    always_ff @(posedge clk) begin
        if (fallingEdge) begin
            if (state == idle) begin
                // Start bit should read 0
                startBad  <= kdataFiltered;
                parityAcc <= 1'b0;
            end else if (state == receiving) begin
                if (bitCount <= 4'd8) begin
                    // Data arrives LSB first
                    shiftReg  <= {kdataFiltered, shiftReg[7:1]};
                    parityAcc <= parityAcc ^ kdataFiltered;
                end else if (bitCount == 4'd9) begin
                    parityAcc <= parityAcc ^ kdataFiltered;
                end else begin
                    // Stop bit should read 1
                    framingBad <= startBad | ~kdataFiltered;
                end
            end
        end
    end

    // Nine bits with odd parity xor to 1
    assign frame.valid        = (state == done);
    assign frame.data         = shiftReg;
    assign frame.parityError  = ~parityAcc;
    assign frame.framingError = framingBad;

    // Frames are far apart, so no back-to-back strobes
    validSinglePulse: assert property (@(posedge clk) disable iff (rst)
        frame.valid |=> !frame.valid);

    bitCountInRange: assert property (@(posedge clk) disable iff (rst)
        bitCount <= 4'd10);

endmodule

`default_nettype wire

// File: logic/ps2KeyAssembler.sv
`timescale 1ns/1ns
`default_nettype none

module ps2KeyAssembler (
    input  logic              clk,
    input  logic              rst,
    ps2FrameIf.receiver       frame,
    output ps2Pkg::scanCode_t keycode,
    output logic              newKeyPress,
    output logic              frameError
);
    import ps2Pkg::*;

    // Prefix bytes seen so far
    scanCode_t history;
    logic      badFrame;
    logic      isPrefix;

    assign badFrame = frame.parityError | frame.framingError;
    assign isPrefix = (frame.data == prefixExtended) || (frame.data == prefixRelease);

    ////////////////////
    // Prefix handling
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            history     <= '0;
            keycode     <= '0;
            newKeyPress <= 1'b0;
            frameError  <= 1'b0;
        end else begin
            // Strobes default low
            newKeyPress <= 1'b0;
            frameError  <= 1'b0;
            if (frame.valid) begin
                if (badFrame) begin
                    // Drop the partial code and keep the last key
                    frameError <= 1'b1;
                    history    <= '0;
                end else if (isPrefix) begin
                    history <= {history[23:0], frame.data};
                end else begin
                    // Final byte closes the code
                    keycode     <= {history[23:0], frame.data};
                    newKeyPress <= 1'b1;
                    history     <= '0;
                end
            end
        end
    end

    strobesExclusive: assert property (@(posedge clk) disable iff (rst)
        !(newKeyPress && frameError));

endmodule

`default_nettype wire

// File: logic/ps2Receiver.sv
`timescale 1ns/1ns
`default_nettype none

module ps2Receiver (
    input  logic              clk,
    input  logic              rst,
    input  logic              kclk,
    input  logic              kdata,
    output ps2Pkg::scanCode_t keycode,
    output logic              newKeyPress,
    output logic              frameError
);

    logic kclkFiltered;
    logic kdataFiltered;

    // Byte link from decoder to assembler
    ps2FrameIf frameLink ();

    // Glitch removal on both raw lines
    ps2LineFilter lineFilter (
        .clk           (clk),
        .rst           (rst),
        .kclk          (kclk),
        .kdata         (kdata),
        .kclkFiltered  (kclkFiltered),
        .kdataFiltered (kdataFiltered)
    );

    ps2FrameDecoder frameDecoder (
        .clk           (clk),
        .rst           (rst),
        .kclkFiltered  (kclkFiltered),
        .kdataFiltered (kdataFiltered),
        .frame         (frameLink.sender)
    );

    // Prefix collection and code output
    ps2KeyAssembler keyAssembler (
        .clk         (clk),
        .rst         (rst),
        .frame       (frameLink.receiver),
        .keycode     (keycode),
        .newKeyPress (newKeyPress),
        .frameError  (frameError)
    );

endmodule

`default_nettype wire

// File: verif/ps2ReceiverTb.sv
`timescale 1ns/1ns
`default_nettype none

module ps2ReceiverTb;
    import ps2Pkg::*;

    ////////////////////
    // Run limits
    ////////////////////

    localparam int numRows     = 9;
    localparam int bitCycles   = 120;
    localparam int maxGap      = 456;
    localparam int cutoffPause = frameTimeoutCycles + 500;
    localparam int waitLimit   = 400;
    // Three frames per row at most, plus gaps, the cut-off pause and the strobe waits
    localparam int cycleLimit  = numRows * 3 * 11 * bitCycles + numRows * 3 * maxGap
                                 + cutoffPause + numRows * (waitLimit + 10) + 200;

    logic      clk;
    logic      rst;
    logic      kclk;
    logic      kdata;
    scanCode_t keycode;
    logic      newKeyPress;
    logic      frameError;

    // Stimulus table, one row per key event
    ps2Byte_t  rowBytes [numRows][3];
    int        rowLen [numRows];
    bit        rowCorrupt [numRows];
    int        rowMode [numRows];   // 0 plain, 1 glitches, 2 cut-off frame first
    scanCode_t rowCode [numRows];
    bit        rowError [numRows];

    int seed       = 17297;
    int errorCount = 0;
    int keyCount   = 0;
    int errCount   = 0;
    int cycleCount = 0;

    ps2Receiver uut (
        .clk         (clk),
        .rst         (rst),
        .kclk        (kclk),
        .kdata       (kdata),
        .keycode     (keycode),
        .newKeyPress (newKeyPress),
        .frameError  (frameError)
    );

    // 40 ns system clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Strobe counters
    always @(posedge clk) begin
        if (!rst) begin
            if (newKeyPress) begin
                keyCount <= keyCount + 1;
            end
            if (frameError) begin
                errCount <= errCount + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run went past %0d clock cycles", cycleLimit);
            $display("Some tests failed");
            $finish;
        end
    end

    ////////////////////
    // Keyboard model
    ////////////////////

    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Short flip of one line, 0 is kclk and 1 is kdata
    task automatic glitchLine(input bit lineSel, input int len);
        @(posedge clk);
        if (lineSel) kdata <= ~kdata;
        else kclk <= ~kclk;
        repeat (len) @(posedge clk);
        if (lineSel) kdata <= ~kdata;
        else kclk <= ~kclk;
    endtask

    // About 120 cycles per bit, data moves while kclk is high
    task automatic sendFrame(input ps2Byte_t value, input bit badParity, input bit glitchy,
                             input int bitLimit);
        logic [10:0] bits;
        // Stop, odd parity, data, start
        bits = {1'b1, (~^value) ^ badParity, value, 1'b0};
        for (int i = 0; i < bitLimit; i++) begin
            @(posedge clk);
            kdata <= bits[i];
            waitCycles(9);
            if (glitchy) glitchLine(1'b0, 8);
            else waitCycles(9);
            waitCycles(11);
            @(posedge clk);
            kclk <= 1'b0;
            waitCycles(19);
            // Data glitch around the sampling point
            if (glitchy) glitchLine(1'b1, 8);
            else waitCycles(9);
            waitCycles(30);
            @(posedge clk);
            kclk <= 1'b1;
            waitCycles(28);
        end
        @(posedge clk);
        kdata <= 1'b1;
    endtask

    task automatic idleGap(input int n, input bit glitchy);
        if (glitchy) begin
            waitCycles(n / 3);
            glitchLine(1'b0, 10);
            waitCycles(n / 3);
            glitchLine(1'b1, 12);
            waitCycles(n / 3);
        end else begin
            waitCycles(n);
        end
    endtask

    task automatic addRow(input int idx, input int len, input ps2Byte_t b0, input ps2Byte_t b1,
                          input ps2Byte_t b2, input bit corrupt, input int mode,
                          input scanCode_t code, input bit isError);
        rowLen[idx]      = len;
        rowBytes[idx][0] = b0;
        rowBytes[idx][1] = b1;
        rowBytes[idx][2] = b2;
        rowCorrupt[idx]  = corrupt;
        rowMode[idx]     = mode;
        rowCode[idx]     = code;
        rowError[idx]    = isError;
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        int gap;
        int snapKeys;
        int snapErrs;
        int waited;
        int expKeys;
        int expErrs;
        rst   = 1'b1;
        kclk  = 1'b1;
        kdata = 1'b1;
        addRow(0, 1, 8'h1C, 8'h00, 8'h00, 1'b0, 0, 32'h0000001C, 1'b0);
        addRow(1, 2, 8'hF0, 8'h1C, 8'h00, 1'b0, 0, 32'h0000F01C, 1'b0);
        addRow(2, 3, 8'hE0, 8'hF0, 8'h74, 1'b0, 0, 32'h00E0F074, 1'b0);
        addRow(3, 2, 8'hE0, 8'h75, 8'h00, 1'b0, 0, 32'h0000E075, 1'b0);
        // Bad parity keeps the last code
        addRow(4, 2, 8'hE0, 8'h75, 8'h00, 1'b1, 0, 32'h0000E075, 1'b1);
        addRow(5, 1, 8'h1C, 8'h00, 8'h00, 1'b0, 0, 32'h0000001C, 1'b0);
        addRow(6, 2, 8'hF0, 8'h1C, 8'h00, 1'b0, 1, 32'h0000F01C, 1'b0);
        addRow(7, 1, 8'h5A, 8'h00, 8'h00, 1'b0, 2, 32'h0000005A, 1'b0);
        addRow(8, 3, 8'hE0, 8'hF0, 8'h74, 1'b0, 1, 32'h00E0F074, 1'b0);

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        waitCycles(50);
        assert (keycode == '0 && keyCount == 0 && errCount == 0) else begin
            $display("CHECK FAILED at %0t: outputs not idle after reset, keycode %h",
                     $time, keycode);
            errorCount++;
        end

        for (int row = 0; row < numRows; row++) begin
            snapKeys = keyCount;
            snapErrs = errCount;
            if (rowMode[row] == 2) begin
                // Four bits, then silence past the decoder timeout
                sendFrame(8'h2B, 1'b0, 1'b0, 4);
                waitCycles(cutoffPause);
            end
            for (int k = 0; k < rowLen[row]; k++) begin
                gap = 200 + ($random(seed) & 255);
                idleGap(gap, rowMode[row] == 1);
                sendFrame(rowBytes[row][k], rowCorrupt[row] && (k == rowLen[row] - 1),
                          rowMode[row] == 1, 11);
            end
            waited = 0;
            while ((keyCount + errCount) == (snapKeys + snapErrs) && waited < waitLimit) begin
                @(posedge clk);
                waited++;
            end
            // Room for a stray second strobe
            waitCycles(5);
            expKeys = rowError[row] ? 0 : 1;
            expErrs = rowError[row] ? 1 : 0;
            assert ((keyCount + errCount) != (snapKeys + snapErrs)) else begin
                $display("Row %0d: neither newKeyPress nor frameError arrived in time", row);
                errorCount++;
            end
            assert (keyCount - snapKeys == expKeys) else begin
                $display("CHECK FAILED at %0t: row %0d saw %0d key strobes, expected %0d",
                         $time, row, keyCount - snapKeys, expKeys);
                errorCount++;
            end
            assert (errCount - snapErrs == expErrs) else begin
                $display("CHECK FAILED at %0t: row %0d saw %0d error strobes, expected %0d",
                         $time, row, errCount - snapErrs, expErrs);
                errorCount++;
            end
            assert (keycode == rowCode[row]) else begin
                $display("CHECK FAILED at %0t: row %0d keycode %h, expected %h",
                         $time, row, keycode, rowCode[row]);
                errorCount++;
            end
        end

        $display("Errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
common/ps2Pkg.sv
common/ps2FrameIf.sv
logic/ps2LineFilter.sv
ps2Frame/ps2FrameDecoder.sv
logic/ps2KeyAssembler.sv
logic/ps2Receiver.sv
verif/ps2ReceiverTb.sv

// File: run.sh
#!/bin/sh
# Build and run the PS/2 receiver testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f src.f \
    --top-module ps2ReceiverTb \
    -o simv

./obj_dir/simv | tee sim.log

if grep -q "All tests passed" sim.log; then
    echo "Simulation result: PASS"
    exit 0
else
    echo "Simulation result: FAIL"
    exit 1
fi
